// ==== orange_tracker_macros.svh ====
// ========================================
// build-time sizes and colour window
// FRAME_WIDTH must be a multiple of three
// depths and credit counts must be >= 2
// ========================================
`ifndef ORANGE_TRACKER_MACROS_SVH
`define ORANGE_TRACKER_MACROS_SVH

// pixels per line, split into left / centre / right thirds
`define FRAME_WIDTH 12

// ingress slots, upstream starts with this many credits
`define INGRESS_DEPTH 4

// egress slots, ingress starts with this many credits toward it
`define EGRESS_DEPTH 4

// credits the egress holds toward the display consumer after reset
`define OUT_CREDITS 4

// orange window on 4-bit components, bounds inclusive
`define R_MIN 10
`define G_MIN 3
`define G_MAX 9
`define B_MAX 5

// orange pixels per frame needed before a target is declared
`define DETECT_MIN 6

`endif

// ==== orange_tracker_pkg.sv ====
// ========================================
// shared types for the tracker datapath
// pixel_t is 15 bits, colour then flags
// ========================================

package orange_tracker_pkg;

  // one RGB444 pixel with its framing flags
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    // first pixel of the frame
    logic       sof;
    // last pixel of a line
    logic       eol;
    // last pixel of the frame
    logic       eof;
  } pixel_t;

  // third of the frame that holds the most orange pixels
  typedef enum logic [1:0] {
    DIR_NONE   = 2'd0,
    DIR_LEFT   = 2'd1,
    DIR_CENTER = 2'd2,
    DIR_RIGHT  = 2'd3
  } direction_e;

endpackage

// ==== pixel_link.sv ====
// ========================================
// credit link, one beat per valid cycle
// sink must never refuse a beat
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

interface pixel_link;

  // beat strobe, only while the source holds a credit
  logic                       valid;
  // pixel payload, meaningful when valid is high
  orange_tracker_pkg::pixel_t pix;
  // one pulse per slot freed in the sink
  logic                       credit;

  // producer side, spends credits
  modport source (
    output valid,
    output pix,
    input  credit
  );

  // consumer side, returns credits
  modport sink (
    input  valid,
    input  pix,
    output credit
  );

endinterface

// ==== pixel_ingress.sv ====
// ========================================
// input FIFO, upstream owns INGRESS_DEPTH
// credits, pops only with a credit held
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

module pixel_ingress (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  orange_tracker_pkg::pixel_t in_pix,
  output logic                       in_credit,
  pixel_link.source                  down
);

  localparam int PTR_W = $clog2(`INGRESS_DEPTH);
  localparam int CNT_W = $clog2(`INGRESS_DEPTH + 1);
  localparam int CRD_W = $clog2(`EGRESS_DEPTH + 1);

  orange_tracker_pkg::pixel_t mem [`INGRESS_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [CRD_W-1:0] credits;
  logic             pop;

  // head leaves as soon as something is stored and a downstream slot is free
  assign pop        = (fill != '0) && (credits != '0);
  assign down.valid = pop;
  assign down.pix   = mem[rd_ptr];
  // freed slot goes straight back upstream
  assign in_credit  = pop;

  // storage, upstream only sends with a credit so no overflow check
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_pix;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      credits <= CRD_W'(`EGRESS_DEPTH);
    end else begin
      // circular pointers, explicit wrap for non power of two depths
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`INGRESS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`INGRESS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // spend on pop, refill on each returned pulse
      case ({pop, down.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// ==== target_finder.sv ====
// ========================================
// one-stage orange mask, never stalls
// credits pass through unchanged
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

module target_finder (
  input  logic      clk,
  input  logic      rst,
  pixel_link.sink   up,
  pixel_link.source down,
  output logic      is_orange
);

  logic                       hit;
  orange_tracker_pkg::pixel_t masked;

  // window test on the incoming colour, bounds inclusive
  assign hit = (up.pix.r >= 4'(`R_MIN)) &&
               (up.pix.g >= 4'(`G_MIN)) &&
               (up.pix.g <= 4'(`G_MAX)) &&
               (up.pix.b <= 4'(`B_MAX));

  // black out anything outside the window
  always_comb begin
    masked = up.pix;
    if (!hit) begin
      masked.r = 4'd0;
      masked.g = 4'd0;
      masked.b = 4'd0;
    end
  end

  // payload register, qualified by down.valid
  always_ff @(posedge clk) begin
    if (up.valid) begin
      down.pix <= masked;
    end
  end

  // beat strobe and decision travel together
  always_ff @(posedge clk) begin
    if (rst) begin
      down.valid <= 1'b0;
      is_orange  <= 1'b0;
    end else begin
      down.valid <= up.valid;
      is_orange  <= up.valid && hit;
    end
  end

  // fixed one-cycle pipe, so egress slots map one to one onto upstream credits
  assign up.credit = down.credit;

endmodule

// ==== classification.sv ====
// ========================================
// per-frame orange count by column third
// result valid from frame_done until next
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

module classification (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           beat_valid,
  input  orange_tracker_pkg::pixel_t     beat_pix,
  input  logic                           is_orange,
  output logic                           frame_done,
  output logic                           orange_detected,
  output orange_tracker_pkg::direction_e direction
);

  localparam int COL_W = $clog2(`FRAME_WIDTH);
  localparam int THIRD = `FRAME_WIDTH / 3;
  localparam int CNT_W = 16;

  logic [COL_W-1:0] col;
  logic [COL_W-1:0] cur_col;
  logic [CNT_W-1:0] cnt_l;
  logic [CNT_W-1:0] cnt_c;
  logic [CNT_W-1:0] cnt_r;
  logic [CNT_W-1:0] nxt_l;
  logic [CNT_W-1:0] nxt_c;
  logic [CNT_W-1:0] nxt_r;
  logic [CNT_W+1:0] total;
  logic             hit;
  orange_tracker_pkg::direction_e best;

  // sof forces column zero even if the previous line was cut short
  assign cur_col = beat_pix.sof ? '0 : col;
  assign hit     = beat_valid && is_orange;

  // counts including the current beat, so the eof pixel is not missed
  assign nxt_l = cnt_l + CNT_W'(hit && (cur_col < COL_W'(THIRD)));
  assign nxt_c = cnt_c + CNT_W'(hit && (cur_col >= COL_W'(THIRD)) &&
                                (cur_col < COL_W'(2 * THIRD)));
  assign nxt_r = cnt_r + CNT_W'(hit && (cur_col >= COL_W'(2 * THIRD)));
  assign total = (CNT_W+2)'(nxt_l) + (CNT_W+2)'(nxt_c) + (CNT_W+2)'(nxt_r);

  // largest third wins, ties go to centre first, then left
  always_comb begin
    if ((nxt_c >= nxt_l) && (nxt_c >= nxt_r)) begin
      best = orange_tracker_pkg::DIR_CENTER;
    end else if (nxt_l >= nxt_r) begin
      best = orange_tracker_pkg::DIR_LEFT;
    end else begin
      best = orange_tracker_pkg::DIR_RIGHT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      col             <= '0;
      cnt_l           <= '0;
      cnt_c           <= '0;
      cnt_r           <= '0;
      frame_done      <= 1'b0;
      orange_detected <= 1'b0;
      direction       <= orange_tracker_pkg::DIR_NONE;
    end else begin
      frame_done <= 1'b0;
      if (beat_valid) begin
        col <= beat_pix.eol ? '0 : cur_col + 1'b1;
        if (beat_pix.eof) begin
          // decision taken on the eof beat, counts restart for the next frame
          frame_done      <= 1'b1;
          orange_detected <= (total >= (CNT_W+2)'(`DETECT_MIN));
          direction       <= (total >= (CNT_W+2)'(`DETECT_MIN)) ?
                             best : orange_tracker_pkg::DIR_NONE;
          cnt_l           <= '0;
          cnt_c           <= '0;
          cnt_r           <= '0;
        end else begin
          cnt_l <= nxt_l;
          cnt_c <= nxt_c;
          cnt_r <= nxt_r;
        end
      end
    end
  end

endmodule

// ==== pixel_egress.sv ====
// ========================================
// output FIFO, spends consumer credits
// consumer owns OUT_CREDITS after reset
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

module pixel_egress (
  input  logic                       clk,
  input  logic                       rst,
  pixel_link.sink                    up,
  output logic                       out_valid,
  output orange_tracker_pkg::pixel_t out_pix,
  input  logic                       out_credit
);

  localparam int PTR_W = $clog2(`EGRESS_DEPTH);
  localparam int CNT_W = $clog2(`EGRESS_DEPTH + 1);
  localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

  orange_tracker_pkg::pixel_t mem [`EGRESS_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [CRD_W-1:0] credits;
  logic             pop;

  // send whenever a pixel waits and the display has room
  assign pop       = (fill != '0) && (credits != '0);
  assign out_valid = pop;
  assign out_pix   = mem[rd_ptr];
  // each pop frees a slot, returned toward the ingress
  assign up.credit = pop;

  always_ff @(posedge clk) begin
    if (up.valid) begin
      mem[wr_ptr] <= up.pix;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      credits <= CRD_W'(`OUT_CREDITS);
    end else begin
      if (up.valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`EGRESS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`EGRESS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({up.valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // external credit pool
      case ({pop, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// ==== orange_tracker.sv ====
// ========================================
// tracker top, single clock clk
// both pixel ports are credit based
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

module orange_tracker (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  logic [3:0] in_r,
  input  logic [3:0] in_g,
  input  logic [3:0] in_b,
  input  logic       in_sof,
  input  logic       in_eol,
  input  logic       in_eof,
  output logic       in_credit,
  output logic       out_valid,
  output logic [3:0] out_r,
  output logic [3:0] out_g,
  output logic [3:0] out_b,
  output logic       out_sof,
  output logic       out_eol,
  output logic       out_eof,
  input  logic       out_credit,
  output logic       frame_done,
  output logic       orange_detected,
  output logic [1:0] direction
);

  orange_tracker_pkg::pixel_t     in_pix;
  orange_tracker_pkg::pixel_t     out_pix;
  orange_tracker_pkg::direction_e dir;
  logic                           is_orange;

  // ingress to finder, finder to egress
  pixel_link link_find ();
  pixel_link link_out ();

  // pack the external pixel
  assign in_pix = '{r: in_r, g: in_g, b: in_b, sof: in_sof, eol: in_eol, eof: in_eof};

  // unpack toward the display
  assign out_r     = out_pix.r;
  assign out_g     = out_pix.g;
  assign out_b     = out_pix.b;
  assign out_sof   = out_pix.sof;
  assign out_eol   = out_pix.eol;
  assign out_eof   = out_pix.eof;
  assign direction = dir;

  pixel_ingress u_ingress (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_pix   (in_pix),
    .in_credit(in_credit),
    .down     (link_find.source)
  );

  target_finder u_finder (
    .clk      (clk),
    .rst      (rst),
    .up       (link_find.sink),
    .down     (link_out.source),
    .is_orange(is_orange)
  );

  // taps the finder output beat, not a link endpoint
  classification u_classifier (
    .clk            (clk),
    .rst            (rst),
    .beat_valid     (link_out.valid),
    .beat_pix       (link_out.pix),
    .is_orange      (is_orange),
    .frame_done     (frame_done),
    .orange_detected(orange_detected),
    .direction      (dir)
  );

  pixel_egress u_egress (
    .clk       (clk),
    .rst       (rst),
    .up        (link_out.sink),
    .out_valid (out_valid),
    .out_pix   (out_pix),
    .out_credit(out_credit)
  );

endmodule

// ==== tb_orange_tracker.sv ====
// ========================================
// random traffic from a 17-bit LFSR
// expects FRAME_WIDTH divisible by three
// ========================================
`timescale 1ns/1ps
`include "orange_tracker_macros.svh"

module tb_orange_tracker;

  localparam int FRAME_PIX  = `FRAME_WIDTH * 3;
  localparam int TOTAL      = 8 * FRAME_PIX;
  localparam int STALL_AT   = 3 * FRAME_PIX + 10;
  localparam int STALL_LEN  = 150;
  localparam int MAX_CYCLES = 20000;

  logic       clk = 1'b0;
  logic       rst;
  logic       in_valid, in_sof, in_eol, in_eof, in_credit;
  logic [3:0] in_r, in_g, in_b;
  logic       out_valid, out_sof, out_eol, out_eof, out_credit;
  logic [3:0] out_r, out_g, out_b;
  logic       frame_done, orange_detected;
  logic [1:0] direction;

  logic [16:0] lfsr = 17'd73199;
  // model queues, filled when a pixel is sent
  logic [14:0] exp_pix_q [$];
  int          exp_det_q [$];
  int          exp_dir_q [$];
  int value_errs, other_errs, cycles;
  int sent, received, up_credits, owed, in_credit_cnt, out_credit_cnt;
  int stall_left, forced_left, frame_bias, cnt_l, cnt_c, cnt_r;
  bit stall_forced;

  orange_tracker uut (.*);

  always #10 clk = ~clk;

  // x^17 + x^14 + 1, new bit shifted in at the bottom
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    lfsr_next = {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      value_errs++;
      $display("ERR %s expected %0h actual %0h at cycle %0d", name, expected, actual, cycles);
    end
  endtask

  function automatic logic orange_hit(input int r, input int g, input int b);
    orange_hit = (r >= `R_MIN) && (g >= `G_MIN) && (g <= `G_MAX) && (b <= `B_MAX);
  endfunction

  // largest third, ties to centre then left, none below the threshold
  function automatic int expected_direction(input int l, input int c, input int r);
    if (l + c + r < `DETECT_MIN) return int'(orange_tracker_pkg::DIR_NONE);
    if (c >= l && c >= r) return int'(orange_tracker_pkg::DIR_CENTER);
    if (l >= r) return int'(orange_tracker_pkg::DIR_LEFT);
    return int'(orange_tracker_pkg::DIR_RIGHT);
  endfunction

  task automatic send_pixel();
    int pos, v, r, g, b, x;
    logic hit, sof, eol, eof;
    pos = sent % FRAME_PIX;
    if (pos == 0) begin
      // per-frame orange bias, out of 8
      take_bits(2, v);
      frame_bias = (v < 2) ? v + 1 : v + 2;
    end
    take_bits(3, v);
    if (v < frame_bias) begin
      take_bits(3, v);
      r = `R_MIN + v % (16 - `R_MIN);
      take_bits(3, v);
      g = `G_MIN + v % (`G_MAX - `G_MIN + 1);
      take_bits(3, v);
      b = v % (`B_MAX + 1);
    end else begin
      take_bits(4, r);
      take_bits(4, g);
      take_bits(4, b);
    end
    x   = pos % `FRAME_WIDTH;
    sof = (pos == 0);
    eol = (x == `FRAME_WIDTH - 1);
    eof = (pos == FRAME_PIX - 1);
    hit = orange_hit(r, g, b);
    if (hit) begin
      if (x < `FRAME_WIDTH / 3) cnt_l++;
      else if (x < 2 * `FRAME_WIDTH / 3) cnt_c++;
      else cnt_r++;
    end
    exp_pix_q.push_back(hit ? {4'(r), 4'(g), 4'(b), sof, eol, eof} : {12'd0, sof, eol, eof});
    if (eof) begin
      exp_det_q.push_back(int'(cnt_l + cnt_c + cnt_r >= `DETECT_MIN));
      exp_dir_q.push_back(expected_direction(cnt_l, cnt_c, cnt_r));
      cnt_l = 0;
      cnt_c = 0;
      cnt_r = 0;
    end
    in_valid = 1'b1;
    in_r     = 4'(r);
    in_g     = 4'(g);
    in_b     = 4'(b);
    in_sof   = sof;
    in_eol   = eol;
    in_eof   = eof;
    sent++;
    up_credits--;
  endtask

  task automatic drive_upstream();
    int v;
    in_valid = 1'b0;
    if (sent < TOTAL && up_credits > 0) begin
      take_bits(2, v);
      if (v != 0) send_pixel();
    end
    // a credit seen now is spent from the next cycle on
    if (in_credit) begin
      in_credit_cnt++;
      up_credits++;
    end
    check_value("in_credit_bound", 1, int'(in_credit_cnt <= sent));
    // every pixel out has left the ingress earlier, so its credit is already back
    check_value("in_credit_returned", 1, int'(in_credit_cnt >= received));
  endtask

  task automatic drive_consumer();
    int v;
    out_credit = 1'b0;
    if (!stall_forced && sent >= STALL_AT) begin
      stall_forced = 1'b1;
      forced_left  = STALL_LEN;
    end
    if (forced_left > 0) begin
      forced_left--;
      // full pipeline by now, upstream must be out of credits
      if (forced_left == 0) check_value("stall_blocks_upstream", 0, up_credits);
    end else if (stall_left > 0) begin
      stall_left--;
    end else begin
      take_bits(5, v);
      if (v == 0) begin
        take_bits(5, v);
        stall_left = 20 + v;
      end else begin
        take_bits(1, v);
        if (owed > 0 && v == 1) begin
          out_credit = 1'b1;
          owed--;
          out_credit_cnt++;
        end
      end
    end
  endtask

  task automatic watch_outputs();
    logic [14:0] exp;
    if (out_valid) begin
      received++;
      owed++;
      if (exp_pix_q.size() == 0) begin
        other_errs++;
        $display("output pixel %0d arrived with nothing pending in the model", received);
      end else begin
        exp = exp_pix_q.pop_front();
        check_value("pixel", int'(exp),
                    int'({out_r, out_g, out_b, out_sof, out_eol, out_eof}));
      end
    end
    check_value("out_credit_bound", 1, int'(received <= `OUT_CREDITS + out_credit_cnt));
    if (frame_done) begin
      if (exp_det_q.size() == 0) begin
        other_errs++;
        $display("frame_done pulsed with no frame completed in the model");
      end else begin
        check_value("orange_detected", exp_det_q.pop_front(), int'(orange_detected));
        check_value("direction", exp_dir_q.pop_front(), int'(direction));
      end
    end
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_r       = 4'd0;
    in_g       = 4'd0;
    in_b       = 4'd0;
    in_sof     = 1'b0;
    in_eol     = 1'b0;
    in_eof     = 1'b0;
    out_credit = 1'b0;
    up_credits = `INGRESS_DEPTH;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle after reset, nothing sent yet
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_value("idle_in_credit", 0, int'(in_credit));
      check_value("idle_out_valid", 0, int'(out_valid));
      check_value("idle_frame_done", 0, int'(frame_done));
      check_value("idle_detected", 0, int'(orange_detected));
      check_value("idle_direction", int'(orange_tracker_pkg::DIR_NONE), int'(direction));
    end
    while (!(sent == TOTAL && exp_pix_q.size() == 0 && exp_det_q.size() == 0) &&
           cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
      watch_outputs();
      drive_upstream();
      drive_consumer();
    end
    in_valid = 1'b0;
    if (cycles >= MAX_CYCLES) begin
      other_errs++;
      $display("timeout, pipeline did not drain after %0d cycles", cycles);
    end
    check_value("pixels_out_equal_in", sent, received);
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== orange_tracker.f ====
+incdir+.
orange_tracker_pkg.sv
pixel_link.sv
pixel_ingress.sv
target_finder.sv
classification.sv
pixel_egress.sv
orange_tracker.sv
tb_orange_tracker.sv

// ==== Makefile ====
# Verilator build and run of the orange tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_orange_tracker
FILELIST  ?= orange_tracker.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
